/* Bender.yml */
package:
  name: soc_bus

sources:
  - include_dirs:
      - design
    files:
      - design/bus_pkg.sv
      - design/periph_pkg.sv
      - design/bus_arbiter.sv
      - design/power_counter.sv
      - design/addr_decoder.sv
      - design/scratch_ram.sv
      - design/simple_device.sv
      - design/switch_led_port.sv
      - design/soc_bus_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - testbench/tb_soc_bus.sv

/* design/addr_decoder.sv */
`timescale 1ns/1ns
`include "bus_defs.svh"

module addr_decoder (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_stb,
    input  bus_pkg::bus_addr_t i_adr,
    input  bus_pkg::bus_data_t i_mem_dat,
    input  bus_pkg::bus_data_t i_smpl_dat,
    input  bus_pkg::bus_data_t i_swled_dat,
    output logic               o_mem_stb,
    output logic               o_smpl_stb,
    output logic               o_swled_stb,
    output logic               o_ack,
    output logic               o_err,
    output bus_pkg::bus_data_t o_rd_dat,
    output bus_pkg::bus_addr_t o_fault_adr
);
    import periph_pkg::*;

    slave_t target;
    slave_t resp_slv;

    // memory and simple device each take a whole 8 MB region
    always_comb begin
        if (i_adr[`MAP_REGION_MSB:`MAP_REGION_LSB] == `MAP_MEM_REGION) begin
            target = SLV_MEM;
        end else if (i_adr[`MAP_REGION_MSB:`MAP_REGION_LSB] == `MAP_SMPL_REGION) begin
            target = SLV_SMPL;
        end else if (i_adr == `MAP_SWLED_ADR) begin
            target = SLV_SWLED;
        end else begin
            target = SLV_NONE;
        end
    end

    assign o_mem_stb   = i_stb && (target == SLV_MEM);
    assign o_smpl_stb  = i_stb && (target == SLV_SMPL);
    assign o_swled_stb = i_stb && (target == SLV_SWLED);

    // one response per strobe, one cycle later
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ack       <= 1'b0;
            o_err       <= 1'b0;
            resp_slv    <= SLV_NONE;
            o_fault_adr <= '0;
        end else begin
            o_ack <= i_stb && (target != SLV_NONE);
            o_err <= i_stb && (target == SLV_NONE);
            if (i_stb) begin
                resp_slv <= target;
            end
            // remember where the last bus error hit
            if (i_stb && (target == SLV_NONE)) begin
                o_fault_adr <= i_adr;
            end
        end
    end

    // slaves already registered their word at the strobe edge
    always_comb begin
        case (resp_slv)
            SLV_MEM:   o_rd_dat = i_mem_dat;
            SLV_SMPL:  o_rd_dat = i_smpl_dat;
            SLV_SWLED: o_rd_dat = i_swled_dat;
            default:   o_rd_dat = '0;
        endcase
    end

endmodule

/* design/bus_arbiter.sv */
`timescale 1ns/1ns

module bus_arbiter (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_a_cyc,
    input  logic               i_a_stb,
    input  logic               i_a_we,
    input  bus_pkg::bus_addr_t i_a_adr,
    input  bus_pkg::bus_data_t i_a_dat,
    input  bus_pkg::bus_sel_t  i_a_sel,
    input  logic               i_b_cyc,
    input  logic               i_b_stb,
    input  logic               i_b_we,
    input  bus_pkg::bus_addr_t i_b_adr,
    input  bus_pkg::bus_data_t i_b_dat,
    input  bus_pkg::bus_sel_t  i_b_sel,
    input  logic               i_ack,
    input  logic               i_err,
    output logic               o_a_ack,
    output logic               o_a_stall,
    output logic               o_a_err,
    output logic               o_b_ack,
    output logic               o_b_stall,
    output logic               o_b_err,
    output logic               o_cyc,
    output logic               o_stb,
    output logic               o_we,
    output bus_pkg::bus_addr_t o_adr,
    output bus_pkg::bus_data_t o_dat,
    output bus_pkg::bus_sel_t  o_sel
);
    import bus_pkg::*;

    master_t owner;
    logic    a_owns;

    assign a_owns = (owner == MASTER_A);

    // ownership only moves while the current owner is idle
    // A wins unless B alone asks for the bus
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            owner <= MASTER_A;
        end else if (!o_cyc) begin
            owner <= (i_b_cyc && !i_a_cyc) ? MASTER_B : MASTER_A;
        end
    end

    // owner request onto the shared bus
    assign o_cyc = a_owns ? i_a_cyc : i_b_cyc;
    assign o_stb = o_cyc && (a_owns ? i_a_stb : i_b_stb);
    assign o_we  = a_owns ? i_a_we : i_b_we;
    assign o_adr = a_owns ? i_a_adr : i_b_adr;
    assign o_dat = a_owns ? i_a_dat : i_b_dat;
    assign o_sel = a_owns ? i_a_sel : i_b_sel;

    // responses go back to the owner only, the other master waits
    assign o_a_ack   = a_owns && i_ack;
    assign o_a_err   = a_owns && i_err;
    assign o_a_stall = !a_owns;
    assign o_b_ack   = !a_owns && i_ack;
    assign o_b_err   = !a_owns && i_err;
    assign o_b_stall = a_owns;

endmodule

/* design/bus_defs.svh */
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// shared bus widths
`define BUS_ADDR_W 30
`define BUS_DATA_W 32
`define BUS_SEL_W 4

// on-chip memory word-address bits, 1024 words
`define RAM_AW 10

// 8 MB regions picked by word address bits 29..21
`define MAP_REGION_MSB 29
`define MAP_REGION_LSB 21
`define MAP_MEM_REGION 9'h000
`define MAP_SMPL_REGION 9'h001

// switch/LED port sits at byte address 0x0100_0004
`define MAP_SWLED_ADR 30'h400001

// identification word of the simple device
`define SMPL_ID_WORD 32'h20191028

`endif

/* design/bus_pkg.sv */
`include "bus_defs.svh"

package bus_pkg;

    // word address, data word and byte-lane mask of the shared bus
    typedef logic [`BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [`BUS_DATA_W-1:0] bus_data_t;
    typedef logic [`BUS_SEL_W-1:0]  bus_sel_t;

    // current owner of the shared bus
    typedef enum logic {
        MASTER_A,
        MASTER_B
    } master_t;

endpackage

/* design/periph_pkg.sv */
package periph_pkg;

    // slave picked by the address decoder
    typedef enum logic [1:0] {
        SLV_MEM,
        SLV_SMPL,
        SLV_SWLED,
        SLV_NONE
    } slave_t;

    // simple device word offsets, address bits 3..0
    typedef enum logic [3:0] {
        SMPL_ID      = 4'd0,
        SMPL_SCRATCH = 4'd1,
        SMPL_ERRADR  = 4'd2,
        SMPL_POWER   = 4'd3,
        SMPL_IRQ     = 4'd4
    } smpl_reg_t;

endpackage

/* design/power_counter.sv */
`timescale 1ns/1ns

module power_counter (
    input  logic               i_clk,
    input  logic               i_rst,
    output bus_pkg::bus_data_t o_count
);

    // top bit is sticky once reached, lower bits keep wrapping
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_count <= '0;
        end else if (!o_count[31]) begin
            o_count <= o_count + 1'b1;
        end else begin
            o_count[30:0] <= o_count[30:0] + 1'b1;
        end
    end

endmodule

/* design/scratch_ram.sv */
`timescale 1ns/1ns
`include "bus_defs.svh"

module scratch_ram (
    input  logic               i_clk,
    input  logic               i_stb,
    input  logic               i_we,
    input  logic [`RAM_AW-1:0] i_adr,
    input  bus_pkg::bus_data_t i_dat,
    input  bus_pkg::bus_sel_t  i_sel,
    output bus_pkg::bus_data_t o_dat
);
    import bus_pkg::*;

    localparam int DEPTH = 1 << `RAM_AW;

    bus_data_t mem [DEPTH];

    // byte-lane writes
    always_ff @(posedge i_clk) begin
        if (i_stb && i_we) begin
            for (int lane = 0; lane < `BUS_SEL_W; lane++) begin
                if (i_sel[lane]) begin
                    mem[i_adr][8*lane +: 8] <= i_dat[8*lane +: 8];
                end
            end
        end
    end

    // read word captured on every strobe, old contents on a write
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_dat <= mem[i_adr];
        end
    end

endmodule

/* design/simple_device.sv */
`timescale 1ns/1ns
`include "bus_defs.svh"

module simple_device (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_stb,
    input  logic               i_we,
    input  logic [3:0]         i_adr,
    input  bus_pkg::bus_data_t i_dat,
    input  bus_pkg::bus_data_t i_count,
    input  bus_pkg::bus_addr_t i_fault_adr,
    output bus_pkg::bus_data_t o_dat,
    output logic               o_irq
);
    import bus_pkg::*;
    import periph_pkg::*;

    bus_data_t scratch;

    // register writes, byte lanes ignored
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            scratch <= '0;
            o_irq   <= 1'b0;
        end else if (i_stb && i_we) begin
            case (smpl_reg_t'(i_adr))
                SMPL_SCRATCH: scratch <= i_dat;
                SMPL_IRQ:     o_irq   <= i_dat[0];
                default: begin
                end
            endcase
        end
    end

    // readback registered at the strobe edge
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            case (smpl_reg_t'(i_adr))
                SMPL_ID:      o_dat <= `SMPL_ID_WORD;
                SMPL_SCRATCH: o_dat <= scratch;
                // word address back as a byte address
                SMPL_ERRADR:  o_dat <= {i_fault_adr, 2'b00};
                SMPL_POWER:   o_dat <= i_count;
                SMPL_IRQ:     o_dat <= {31'h0, o_irq};
                default:      o_dat <= '0;
            endcase
        end
    end

endmodule

/* design/soc_bus_top.sv */
`timescale 1ns/1ns
`include "bus_defs.svh"

module soc_bus_top (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_a_cyc,
    input  logic                   i_a_stb,
    input  logic                   i_a_we,
    input  logic [`BUS_ADDR_W-1:0] i_a_adr,
    input  logic [`BUS_DATA_W-1:0] i_a_dat,
    input  logic [`BUS_SEL_W-1:0]  i_a_sel,
    output logic                   o_a_ack,
    output logic                   o_a_stall,
    output logic                   o_a_err,
    input  logic                   i_b_cyc,
    input  logic                   i_b_stb,
    input  logic                   i_b_we,
    input  logic [`BUS_ADDR_W-1:0] i_b_adr,
    input  logic [`BUS_DATA_W-1:0] i_b_dat,
    input  logic [`BUS_SEL_W-1:0]  i_b_sel,
    output logic                   o_b_ack,
    output logic                   o_b_stall,
    output logic                   o_b_err,
    output logic [`BUS_DATA_W-1:0] o_rd_dat,
    input  logic [15:0]            i_switches,
    output logic [15:0]            o_leds,
    output logic                   o_irq
);

    // shared bus after arbitration
    logic                   bus_stb;
    logic                   bus_we;
    logic [`BUS_ADDR_W-1:0] bus_adr;
    logic [`BUS_DATA_W-1:0] bus_dat;
    logic [`BUS_SEL_W-1:0]  bus_sel;
    logic                   bus_ack;
    logic                   bus_err;

    // per-slave strobes and read words
    logic                   mem_stb;
    logic                   smpl_stb;
    logic                   swled_stb;
    logic [`BUS_DATA_W-1:0] mem_dat;
    logic [`BUS_DATA_W-1:0] smpl_dat;
    logic [`BUS_DATA_W-1:0] swled_dat;

    logic [`BUS_ADDR_W-1:0] fault_adr;
    logic [`BUS_DATA_W-1:0] power_count;

    // slaves here answer in one cycle and never look at cyc
    bus_arbiter u_arbiter (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_a_cyc   (i_a_cyc),
        .i_a_stb   (i_a_stb),
        .i_a_we    (i_a_we),
        .i_a_adr   (i_a_adr),
        .i_a_dat   (i_a_dat),
        .i_a_sel   (i_a_sel),
        .i_b_cyc   (i_b_cyc),
        .i_b_stb   (i_b_stb),
        .i_b_we    (i_b_we),
        .i_b_adr   (i_b_adr),
        .i_b_dat   (i_b_dat),
        .i_b_sel   (i_b_sel),
        .i_ack     (bus_ack),
        .i_err     (bus_err),
        .o_a_ack   (o_a_ack),
        .o_a_stall (o_a_stall),
        .o_a_err   (o_a_err),
        .o_b_ack   (o_b_ack),
        .o_b_stall (o_b_stall),
        .o_b_err   (o_b_err),
        .o_cyc     (),
        .o_stb     (bus_stb),
        .o_we      (bus_we),
        .o_adr     (bus_adr),
        .o_dat     (bus_dat),
        .o_sel     (bus_sel)
    );

    addr_decoder u_decoder (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_stb       (bus_stb),
        .i_adr       (bus_adr),
        .i_mem_dat   (mem_dat),
        .i_smpl_dat  (smpl_dat),
        .i_swled_dat (swled_dat),
        .o_mem_stb   (mem_stb),
        .o_smpl_stb  (smpl_stb),
        .o_swled_stb (swled_stb),
        .o_ack       (bus_ack),
        .o_err       (bus_err),
        .o_rd_dat    (o_rd_dat),
        .o_fault_adr (fault_adr)
    );

    // memory region aliases every 1024 words
    scratch_ram u_ram (
        .i_clk (i_clk),
        .i_stb (mem_stb),
        .i_we  (bus_we),
        .i_adr (bus_adr[`RAM_AW-1:0]),
        .i_dat (bus_dat),
        .i_sel (bus_sel),
        .o_dat (mem_dat)
    );

    simple_device u_smpl (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_stb       (smpl_stb),
        .i_we        (bus_we),
        .i_adr       (bus_adr[3:0]),
        .i_dat       (bus_dat),
        .i_count     (power_count),
        .i_fault_adr (fault_adr),
        .o_dat       (smpl_dat),
        .o_irq       (o_irq)
    );

    switch_led_port u_swled (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_stb      (swled_stb),
        .i_we       (bus_we),
        .i_dat      (bus_dat),
        .i_sel      (bus_sel[1:0]),
        .i_switches (i_switches),
        .o_dat      (swled_dat),
        .o_leds     (o_leds)
    );

    power_counter u_power (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .o_count (power_count)
    );

endmodule

/* design/switch_led_port.sv */
`timescale 1ns/1ns

module switch_led_port (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_stb,
    input  logic               i_we,
    input  bus_pkg::bus_data_t i_dat,
    input  logic [1:0]         i_sel,
    input  logic [15:0]        i_switches,
    output bus_pkg::bus_data_t o_dat,
    output logic [15:0]        o_leds
);

    // only the two low byte lanes reach the LEDs
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_leds <= '0;
        end else if (i_stb && i_we) begin
            if (i_sel[0]) begin
                o_leds[7:0] <= i_dat[7:0];
            end
            if (i_sel[1]) begin
                o_leds[15:8] <= i_dat[15:8];
            end
        end
    end

    // switches above, LEDs below
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_dat <= {i_switches, o_leds};
        end
    end

endmodule

/* sources.f */
+incdir+design
design/bus_pkg.sv
design/periph_pkg.sv
design/bus_arbiter.sv
design/power_counter.sv
design/addr_decoder.sv
design/scratch_ram.sv
design/simple_device.sv
design/switch_led_port.sv
design/soc_bus_top.sv
testbench/tb_soc_bus.sv

/* testbench/tb_soc_bus.sv */
`timescale 1ns/1ns
`include "bus_defs.svh"

module tb_soc_bus;
    import bus_pkg::*;
    import periph_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int MEM_WORDS    = 16;
    // full write, lane write and read for every memory word
    localparam int MEM_XFERS    = 3 * MEM_WORDS;
    // simple device 6, bus error 2, arbitration 3, power 1, switch/LED 2
    localparam int NUM_XFERS      = MEM_XFERS + 6 + 2 + 3 + 1 + 2;
    localparam int TIMEOUT_CYCLES = NUM_XFERS * 4 + RESET_CYCLES;

    logic        i_clk;
    logic        i_rst;
    logic        i_a_cyc;
    logic        i_a_stb;
    logic        i_a_we;
    bus_addr_t   i_a_adr;
    bus_data_t   i_a_dat;
    bus_sel_t    i_a_sel;
    logic        o_a_ack;
    logic        o_a_stall;
    logic        o_a_err;
    logic        i_b_cyc;
    logic        i_b_stb;
    logic        i_b_we;
    bus_addr_t   i_b_adr;
    bus_data_t   i_b_dat;
    bus_sel_t    i_b_sel;
    logic        o_b_ack;
    logic        o_b_stall;
    logic        o_b_err;
    bus_data_t   o_rd_dat;
    logic [15:0] i_switches;
    logic [15:0] o_leds;
    logic        o_irq;

    // reference model state
    bus_data_t   model_mem [1 << `RAM_AW];
    bus_data_t   model_scratch;
    logic        model_irq;
    bus_addr_t   model_fault;
    logic [15:0] model_leds;
    bus_data_t   model_count;
    master_t     model_owner;
    bus_data_t   accept_count;
    integer      seed;
    int          cycle_count;

    soc_bus_top i_dut (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_a_cyc    (i_a_cyc),
        .i_a_stb    (i_a_stb),
        .i_a_we     (i_a_we),
        .i_a_adr    (i_a_adr),
        .i_a_dat    (i_a_dat),
        .i_a_sel    (i_a_sel),
        .o_a_ack    (o_a_ack),
        .o_a_stall  (o_a_stall),
        .o_a_err    (o_a_err),
        .i_b_cyc    (i_b_cyc),
        .i_b_stb    (i_b_stb),
        .i_b_we     (i_b_we),
        .i_b_adr    (i_b_adr),
        .i_b_dat    (i_b_dat),
        .i_b_sel    (i_b_sel),
        .o_b_ack    (o_b_ack),
        .o_b_stall  (o_b_stall),
        .o_b_err    (o_b_err),
        .o_rd_dat   (o_rd_dat),
        .i_switches (i_switches),
        .o_leds     (o_leds),
        .o_irq      (o_irq)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // owner moves only while the current owner is idle
    // A wins ties
    always @(posedge i_clk) begin
        if (i_rst) begin
            model_owner <= MASTER_A;
        end else if (!((model_owner == MASTER_A) ? i_a_cyc : i_b_cyc)) begin
            model_owner <= (i_b_cyc && !i_a_cyc) ? MASTER_B : MASTER_A;
        end
    end

    // edges since reset release
    always @(posedge i_clk) begin
        if (i_rst) begin
            model_count <= '0;
        end else begin
            model_count <= model_count + 1'b1;
        end
    end

    always @(posedge i_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run passed %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: got 0x%08h expected 0x%08h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    function automatic bus_data_t rand_word();
        return $random(seed);
    endfunction

    function automatic master_t pick_master();
        bus_data_t word;
        word = rand_word();
        return word[0] ? MASTER_B : MASTER_A;
    endfunction

    function automatic string port_name(input master_t m, input string suffix);
        return $sformatf("o_%s_%s", (m == MASTER_A) ? "a" : "b", suffix);
    endfunction

    function automatic logic ack_of(input master_t m);
        return (m == MASTER_A) ? o_a_ack : o_b_ack;
    endfunction

    function automatic logic err_of(input master_t m);
        return (m == MASTER_A) ? o_a_err : o_b_err;
    endfunction

    function automatic logic stall_of(input master_t m);
        return (m == MASTER_A) ? o_a_stall : o_b_stall;
    endfunction

    function automatic bus_addr_t smpl_addr(input smpl_reg_t r);
        logic [3:0] off;
        off = r;
        return {`MAP_SMPL_REGION, 17'h0, off};
    endfunction

    // enabled byte lanes take the new word
    function automatic bus_data_t merge_lanes(input bus_data_t old_word,
                                              input bus_data_t new_word,
                                              input bus_sel_t  sel);
        bus_data_t result;
        result = old_word;
        for (int lane = 0; lane < `BUS_SEL_W; lane++) begin
            if (sel[lane]) begin
                result[8*lane +: 8] = new_word[8*lane +: 8];
            end
        end
        return result;
    endfunction

    task automatic drive_master(input master_t m, input logic cyc, input logic stb,
                                input logic we, input bus_addr_t adr,
                                input bus_data_t dat, input bus_sel_t sel);
        if (m == MASTER_A) begin
            i_a_cyc = cyc;
            i_a_stb = stb;
            i_a_we  = we;
            i_a_adr = adr;
            i_a_dat = dat;
            i_a_sel = sel;
        end else begin
            i_b_cyc = cyc;
            i_b_stb = stb;
            i_b_we  = we;
            i_b_adr = adr;
            i_b_dat = dat;
            i_b_sel = sel;
        end
    endtask

    // starts on a falling edge and returns on the one where the response shows
    task automatic do_xfer(input master_t m, input logic we, input bus_addr_t adr,
                           input bus_data_t dat, input bus_sel_t sel,
                           output bus_data_t rdat, output logic got_ack,
                           output logic got_err);
        master_t other;
        logic    stalled;
        other = (m == MASTER_A) ? MASTER_B : MASTER_A;
        drive_master(m, 1'b1, 1'b1, we, adr, dat, sel);
        #10;
        stalled = stall_of(m);
        check_value(port_name(m, "stall"), stalled, model_owner != m);
        while (stalled) begin
            @(negedge i_clk);
            #10;
            stalled = stall_of(m);
            check_value(port_name(m, "stall"), stalled, model_owner != m);
        end
        // counter value the simple device sees at the strobe edge
        accept_count = model_count;
        @(negedge i_clk);
        got_ack = ack_of(m);
        got_err = err_of(m);
        rdat    = o_rd_dat;
        check_value(port_name(other, "ack"), ack_of(other), 1'b0);
        check_value(port_name(other, "err"), err_of(other), 1'b0);
        drive_master(m, 1'b1, 1'b0, we, adr, dat, sel);
    endtask

    task automatic write_word(input master_t m, input bus_addr_t adr,
                              input bus_data_t dat, input bus_sel_t sel);
        bus_data_t rdat;
        logic      got_ack;
        logic      got_err;
        do_xfer(m, 1'b1, adr, dat, sel, rdat, got_ack, got_err);
        check_value(port_name(m, "ack"), got_ack, 1'b1);
        check_value(port_name(m, "err"), got_err, 1'b0);
    endtask

    task automatic read_word(input master_t m, input bus_addr_t adr, input bus_data_t exp);
        bus_data_t rdat;
        logic      got_ack;
        logic      got_err;
        do_xfer(m, 1'b0, adr, '0, 4'hF, rdat, got_ack, got_err);
        check_value(port_name(m, "ack"), got_ack, 1'b1);
        check_value(port_name(m, "err"), got_err, 1'b0);
        check_value("o_rd_dat", rdat, exp);
    endtask

    task automatic end_cycle(input master_t m);
        drive_master(m, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        @(negedge i_clk);
    endtask

    task automatic exercise_memory();
        bus_addr_t          adrs [MEM_WORDS];
        bus_addr_t          alias_adr;
        bus_data_t          word;
        bus_data_t          data;
        bus_sel_t           sel;
        master_t            m;
        logic [`RAM_AW-1:0] idx;
        int                 i;
        // fill every word first so no read hits unwritten memory
        for (i = 0; i < MEM_WORDS; i++) begin
            word    = rand_word();
            adrs[i] = {`MAP_MEM_REGION, word[20:0]};
            idx     = adrs[i][`RAM_AW-1:0];
            data    = rand_word();
            m       = pick_master();
            write_word(m, adrs[i], data, 4'hF);
            model_mem[idx] = data;
            end_cycle(m);
        end
        for (i = 0; i < MEM_WORDS; i++) begin
            idx  = adrs[i][`RAM_AW-1:0];
            word = rand_word();
            sel  = word[3:0];
            data = rand_word();
            m    = pick_master();
            write_word(m, adrs[i], data, sel);
            model_mem[idx] = merge_lanes(model_mem[idx], data, sel);
            end_cycle(m);
        end
        // read back through another alias of the same word
        for (i = 0; i < MEM_WORDS; i++) begin
            idx       = adrs[i][`RAM_AW-1:0];
            word      = rand_word();
            alias_adr = {`MAP_MEM_REGION, word[20:10], idx};
            m         = pick_master();
            read_word(m, alias_adr, model_mem[idx]);
            end_cycle(m);
        end
    endtask

    task automatic probe_simple_device();
        master_t   m;
        bus_data_t word;
        bus_data_t data;
        m    = pick_master();
        word = rand_word();
        data = rand_word();
        read_word(m, smpl_addr(SMPL_ID), `SMPL_ID_WORD);
        // byte lanes do not matter here
        write_word(m, smpl_addr(SMPL_SCRATCH), data, word[3:0]);
        model_scratch = data;
        read_word(m, smpl_addr(SMPL_SCRATCH), model_scratch);
        check_value("o_irq", o_irq, model_irq);
        write_word(m, smpl_addr(SMPL_IRQ), data | 32'h1, 4'hF);
        model_irq = 1'b1;
        check_value("o_irq", o_irq, model_irq);
        read_word(m, smpl_addr(SMPL_IRQ), {31'h0, model_irq});
        write_word(m, smpl_addr(SMPL_IRQ), data & ~32'h1, 4'hF);
        model_irq = 1'b0;
        check_value("o_irq", o_irq, model_irq);
        end_cycle(m);
    endtask

    task automatic provoke_bus_error();
        master_t    m;
        bus_data_t  word;
        bus_data_t  rdat;
        bus_data_t  fault_byte;
        bus_addr_t  adr;
        logic [8:0] region;
        logic       got_ack;
        logic       got_err;
        // regions 0 to 2 hold memory, simple device and the switch/LED word
        region = 9'd3 + 9'($unsigned(rand_word()) % 509);
        word   = rand_word();
        adr    = {region, word[20:0]};
        m      = pick_master();
        do_xfer(m, 1'b0, adr, '0, 4'hF, rdat, got_ack, got_err);
        check_value(port_name(m, "ack"), got_ack, 1'b0);
        check_value(port_name(m, "err"), got_err, 1'b1);
        check_value("o_rd_dat", rdat, 32'h0);
        model_fault = adr;
        end_cycle(m);
        // four bytes per word
        fault_byte = bus_data_t'(model_fault) * 4;
        m = pick_master();
        read_word(m, smpl_addr(SMPL_ERRADR), fault_byte);
        end_cycle(m);
    endtask

    task automatic contend_for_bus();
        bus_addr_t adr;
        bus_data_t data;
        bus_data_t rdat;
        logic      got_ack;
        logic      got_err;
        logic      a_done;
        a_done = 1'b0;
        data   = rand_word();
        adr    = {`MAP_MEM_REGION, 11'h0, 10'h3f5};
        // both masters ask for an idle bus on the same edge
        fork
            begin
                write_word(MASTER_A, adr, data, 4'hF);
                model_mem[adr[`RAM_AW-1:0]] = data;
                check_value("o_b_stall", o_b_stall, 1'b1);
                read_word(MASTER_A, adr, data);
                check_value("o_b_stall", o_b_stall, 1'b1);
                drive_master(MASTER_A, 1'b0, 1'b0, 1'b0, '0, '0, '0);
                a_done = 1'b1;
            end
            begin
                do_xfer(MASTER_B, 1'b0, adr, '0, 4'hF, rdat, got_ack, got_err);
                check_value("a_cyc_released", a_done, 1'b1);
                check_value("o_b_ack", got_ack, 1'b1);
                check_value("o_b_err", got_err, 1'b0);
                check_value("o_rd_dat", rdat, model_mem[adr[`RAM_AW-1:0]]);
            end
        join
        end_cycle(MASTER_B);
    endtask

    task automatic read_power_count();
        master_t   m;
        bus_data_t rdat;
        logic      got_ack;
        logic      got_err;
        m = pick_master();
        do_xfer(m, 1'b0, smpl_addr(SMPL_POWER), '0, 4'hF, rdat, got_ack, got_err);
        check_value(port_name(m, "ack"), got_ack, 1'b1);
        check_value(port_name(m, "err"), got_err, 1'b0);
        check_value("o_rd_dat", rdat, accept_count);
        end_cycle(m);
    endtask

    task automatic drive_switch_led();
        master_t   m;
        bus_data_t word;
        bus_data_t data;
        bus_data_t merged;
        m          = pick_master();
        word       = rand_word();
        i_switches = word[31:16];
        data       = rand_word();
        write_word(m, `MAP_SWLED_ADR, data, word[3:0]);
        // only lanes 0 and 1 exist on the LED register
        merged     = merge_lanes({16'h0, model_leds}, data, {2'b00, word[1:0]});
        model_leds = merged[15:0];
        check_value("o_leds", o_leds, model_leds);
        read_word(m, `MAP_SWLED_ADR, {i_switches, model_leds});
        end_cycle(m);
    endtask

    initial begin
        seed          = 32'he2b2;
        cycle_count   = 0;
        model_scratch = '0;
        model_irq     = 1'b0;
        model_fault   = '0;
        model_leds    = '0;
        i_rst         = 1'b1;
        i_switches    = '0;
        drive_master(MASTER_A, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        drive_master(MASTER_B, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        repeat (RESET_CYCLES) @(negedge i_clk);
        i_rst = 1'b0;
        check_value("o_a_ack", o_a_ack, 1'b0);
        check_value("o_a_err", o_a_err, 1'b0);
        check_value("o_b_ack", o_b_ack, 1'b0);
        check_value("o_b_err", o_b_err, 1'b0);
        check_value("o_irq", o_irq, model_irq);
        check_value("o_leds", o_leds, model_leds);
        exercise_memory();
        probe_simple_device();
        provoke_bus_error();
        contend_for_bus();
        read_power_count();
        drive_switch_led();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
